/* verilog/crtc_consts.svh */
`ifndef CRTC_CONSTS_SVH
`define CRTC_CONSTS_SVH

// Register indices, 6545 order
`define CRTC_R0                 5'd0    // Horizontal total (-1)
`define CRTC_R1                 5'd1    // Horizontal displayed
`define CRTC_R2                 5'd2    // Horizontal sync position
`define CRTC_R3                 5'd3    // Sync widths, v in 7:4 and h in 3:0
`define CRTC_R4                 5'd4    // Vertical total (-1)
`define CRTC_R5                 5'd5    // Vertical adjust in scanlines
`define CRTC_R6                 5'd6    // Vertical displayed
`define CRTC_R7                 5'd7    // Vertical sync position
`define CRTC_R9                 5'd9    // Scan lines per character row (-1)

// Reset values, roughly NTSC timing
`define CRTC_R0_DEFAULT         8'd63
`define CRTC_R1_DEFAULT         8'd40
`define CRTC_R2_DEFAULT         8'd48
`define CRTC_R3_DEFAULT         8'h15
`define CRTC_R4_DEFAULT         8'd32
`define CRTC_R5_DEFAULT         5'd0
`define CRTC_R6_DEFAULT         8'd25
`define CRTC_R7_DEFAULT         8'd28
`define CRTC_R9_DEFAULT         5'd7

`define CRTC_CHAR_WIDTH         7       // Pixels per character (-1)

// Bus map, RAM below this bit and character ROM above
`define CRTC_ROM_BASE_BIT       11

`endif

/* verilog/crtc_cfg_pkg.sv */
package crtc_cfg_pkg;

    // Register selector on the write port
    typedef logic [4:0] reg_index_t;

    // Character count or index along one axis
    typedef logic [7:0] char_count_t;

    // Pixels or scanlines within a character (-1)
    typedef logic [4:0] pixel_count_t;

    // Sync width in characters, 0 stands for 16
    typedef logic [3:0] sync_width_t;

    // Programmed timing of one raster axis
    typedef struct packed {
        pixel_count_t   pixel_size;     // Steps per character (-1)
        char_count_t    total;          // Characters per line or frame (-1)
        char_count_t    displayed;      // Visible characters
        char_count_t    sync_start;     // Character where sync begins
        sync_width_t    sync_width;     // Sync length in characters
        pixel_count_t   adjust;         // Extra steps after the last character
    } axis_cfg_t;

endpackage

/* verilog/raster_pkg.sv */
package raster_pkg;

    // Phase of a raster axis within its line or frame
    typedef enum logic [2:0] {
        ACTIVE,                         // Visible characters
        FRONT,                          // Blank before sync
        SYNC,                           // Sync pulse
        BACK,                           // Blank after sync
        ADJUST                          // Extra steps past the total
    } axis_state_t;

    // Running position of one axis
    typedef struct packed {
        crtc_cfg_pkg::char_count_t    char_index;   // Current character
        crtc_cfg_pkg::pixel_count_t   pixel_index;  // Step within the character
        logic                         first;        // First step of the character
        logic                         last;         // Last step of the character
        logic                         line_end;     // Last step of the last character
        logic                         active;       // Visible area
        logic                         sync;         // Sync pulse
    } axis_pos_t;

    // Shared RAM and ROM address bus
    typedef logic [11:0] bus_addr_t;

endpackage

/* verilog/crtc_regs.sv */
`timescale 1ns/1ps
`include "crtc_consts.svh"

module crtc_regs (
    input  logic                        pixel_clk_i,
    input  logic                        reset_i,
    input  crtc_cfg_pkg::reg_index_t    reg_sel_i,
    input  logic [7:0]                  reg_data_i,
    input  logic                        reg_write_i,
    output crtc_cfg_pkg::axis_cfg_t     h_cfg_o,
    output crtc_cfg_pkg::axis_cfg_t     v_cfg_o
);
    crtc_cfg_pkg::char_count_t      h_total;
    crtc_cfg_pkg::char_count_t      h_displayed;
    crtc_cfg_pkg::char_count_t      h_sync_pos;
    logic [7:0]                     sync_widths;    // R3, both nibbles
    crtc_cfg_pkg::char_count_t      v_total;
    crtc_cfg_pkg::pixel_count_t     v_adjust;
    crtc_cfg_pkg::char_count_t      v_displayed;
    crtc_cfg_pkg::char_count_t      v_sync_pos;
    crtc_cfg_pkg::pixel_count_t     scan_lines;

    always_ff @(posedge pixel_clk_i or posedge reset_i) begin
        if (reset_i) begin
            h_total     <= `CRTC_R0_DEFAULT;
            h_displayed <= `CRTC_R1_DEFAULT;
            h_sync_pos  <= `CRTC_R2_DEFAULT;
            sync_widths <= `CRTC_R3_DEFAULT;
            v_total     <= `CRTC_R4_DEFAULT;
            v_adjust    <= `CRTC_R5_DEFAULT;
            v_displayed <= `CRTC_R6_DEFAULT;
            v_sync_pos  <= `CRTC_R7_DEFAULT;
            scan_lines  <= `CRTC_R9_DEFAULT;
        end else if (reg_write_i) begin
            case (reg_sel_i)
                `CRTC_R0: h_total     <= reg_data_i;
                `CRTC_R1: h_displayed <= reg_data_i;
                `CRTC_R2: h_sync_pos  <= reg_data_i;
                `CRTC_R3: sync_widths <= reg_data_i;
                `CRTC_R4: v_total     <= reg_data_i;
                `CRTC_R5: v_adjust    <= reg_data_i[4:0];
                `CRTC_R6: v_displayed <= reg_data_i;
                `CRTC_R7: v_sync_pos  <= reg_data_i;
                `CRTC_R9: scan_lines  <= reg_data_i[4:0];
                default: ;                                  // R8 and unknown indices
            endcase
        end
    end

    // Horizontal cells are fixed width and never adjust
    assign h_cfg_o.pixel_size = crtc_cfg_pkg::pixel_count_t'(`CRTC_CHAR_WIDTH);
    assign h_cfg_o.total      = h_total;
    assign h_cfg_o.displayed  = h_displayed;
    assign h_cfg_o.sync_start = h_sync_pos;
    assign h_cfg_o.sync_width = sync_widths[3:0];
    assign h_cfg_o.adjust     = '0;

    // Vertical character fields are 7 bits wide on the 6545
    assign v_cfg_o.pixel_size = scan_lines;
    assign v_cfg_o.total      = {1'b0, v_total[6:0]};
    assign v_cfg_o.displayed  = {1'b0, v_displayed[6:0]};
    assign v_cfg_o.sync_start = {1'b0, v_sync_pos[6:0]};
    assign v_cfg_o.sync_width = sync_widths[7:4];
    assign v_cfg_o.adjust     = v_adjust;

endmodule

/* verilog/raster_axis.sv */
`timescale 1ns/1ps

module raster_axis (
    input  logic                        pixel_clk_i,
    input  logic                        reset_i,
    input  logic                        step_i,
    input  crtc_cfg_pkg::axis_cfg_t     cfg_i,
    output raster_pkg::axis_pos_t       pos_o
);
    crtc_cfg_pkg::pixel_count_t     pixel_count;    // Step within character or adjust
    crtc_cfg_pkg::char_count_t      char_count;
    crtc_cfg_pkg::char_count_t      next_char;
    crtc_cfg_pkg::char_count_t      sync_end;       // First character after sync
    raster_pkg::axis_state_t        state;
    raster_pkg::axis_state_t        next_state;
    logic                           first_step;
    logic                           last_step;
    logic                           in_adjust;
    logic                           adjust_done;

    assign first_step  = pixel_count == '0;
    assign last_step   = pixel_count == cfg_i.pixel_size;
    assign in_adjust   = state == raster_pkg::ADJUST;
    assign adjust_done = pixel_count == cfg_i.adjust - 5'd1;
    assign next_char   = char_count + 8'd1;

    // Width 0 encodes a 16 character pulse
    assign sync_end = cfg_i.sync_start
                    + {3'b000, cfg_i.sync_width == '0, cfg_i.sync_width};

    // State seen by the character that starts next
    always_comb begin
        next_state = state;
        if (next_char == sync_end)
            next_state = raster_pkg::BACK;
        else if (next_char == cfg_i.sync_start)
            next_state = raster_pkg::SYNC;
        else if (next_char == cfg_i.displayed)
            next_state = raster_pkg::FRONT;
    end

    always_ff @(posedge pixel_clk_i or posedge reset_i) begin
        if (reset_i) begin
            pixel_count <= '0;
            char_count  <= '0;
            state       <= raster_pkg::ACTIVE;
        end else if (step_i) begin
            if (in_adjust) begin
                if (adjust_done) begin                      // Adjust over, restart
                    pixel_count <= '0;
                    char_count  <= '0;
                    state       <= raster_pkg::ACTIVE;
                end else begin
                    pixel_count <= pixel_count + 5'd1;
                end
            end else if (last_step) begin
                pixel_count <= '0;
                if (char_count == cfg_i.total) begin
                    if (cfg_i.adjust != '0) begin
                        state <= raster_pkg::ADJUST;        // Char index holds at total
                    end else begin
                        char_count <= '0;
                        state      <= raster_pkg::ACTIVE;
                    end
                end else begin
                    char_count <= next_char;
                    state      <= next_state;
                end
            end else begin
                pixel_count <= pixel_count + 5'd1;
            end
        end
    end

    assign pos_o.char_index  = char_count;
    assign pos_o.pixel_index = pixel_count;
    assign pos_o.first       = first_step;
    assign pos_o.last        = last_step;
    assign pos_o.line_end    = last_step && (char_count == cfg_i.total) && !in_adjust;
    assign pos_o.active      = state == raster_pkg::ACTIVE;
    assign pos_o.sync        = state == raster_pkg::SYNC;

endmodule

/* verilog/char_fetch.sv */
`timescale 1ns/1ps
`include "crtc_consts.svh"

module char_fetch (
    input  logic                        pixel_clk_i,
    input  logic                        reset_i,
    input  raster_pkg::axis_pos_t       h_pos_i,
    input  raster_pkg::axis_pos_t       v_pos_i,
    input  crtc_cfg_pkg::char_count_t   h_displayed_i,
    output raster_pkg::bus_addr_t       bus_addr_o,
    input  logic [7:0]                  bus_data_i,
    output logic                        video_o
);
    localparam int RAM_AW = `CRTC_ROM_BASE_BIT;

    typedef logic [RAM_AW-1:0] ram_addr_t;

    ram_addr_t                  row_base;       // RAM address of column 0 in this row
    ram_addr_t                  row_base_next;
    ram_addr_t                  col_addr;       // RAM address of the cell being fetched
    raster_pkg::bus_addr_t      rom_addr;
    logic                       code_slot;
    logic                       glyph_slot;
    logic                       row_restart;
    logic                       row_advance;
    logic                       next_reverse;   // Bit 7 of the fetched code
    logic [7:0]                 glyph;
    logic [7:0]                 glyph_load;
    logic [7:0]                 shifter;
    logic                       reverse;
    logic                       show;           // Display enable, one cell late

    assign code_slot  = h_pos_i.pixel_index == 5'd1;
    assign glyph_slot = h_pos_i.pixel_index == 5'd2;

    // Frame wrap or v sync restarts the row base
    assign row_restart = v_pos_i.sync || (h_pos_i.line_end && v_pos_i.line_end);
    assign row_advance = h_pos_i.line_end && v_pos_i.last && v_pos_i.active;

    always_comb begin
        row_base_next = row_base;
        if (row_restart)
            row_base_next = '0;
        else if (row_advance)
            row_base_next = row_base + ram_addr_t'(h_displayed_i);
    end

    // Glyph row lookup straight from the code on the bus
    always_comb begin
        rom_addr                     = '0;
        rom_addr[`CRTC_ROM_BASE_BIT] = 1'b1;
        rom_addr[9:0]                = {bus_data_i[6:0], v_pos_i.pixel_index[2:0]};
    end

    assign bus_addr_o = code_slot ? rom_addr : raster_pkg::bus_addr_t'(col_addr);

    always_ff @(posedge pixel_clk_i) begin
        if (code_slot) begin
            next_reverse <= bus_data_i[7];
        end
        if (glyph_slot) begin
            glyph <= bus_data_i;
        end
    end

    // A 3 pixel cell loads the shifter in the glyph slot itself
    assign glyph_load = glyph_slot ? bus_data_i : glyph;

    always_ff @(posedge pixel_clk_i or posedge reset_i) begin
        if (reset_i) begin
            row_base <= '0;
            col_addr <= '0;
            shifter  <= '0;
            reverse  <= 1'b0;
            show     <= 1'b0;
        end else begin
            row_base <= row_base_next;
            if (h_pos_i.line_end) begin
                col_addr <= row_base_next;                  // Column 0 of the next line
            end else if (h_pos_i.last) begin
                col_addr <= col_addr + 1'b1;
            end
            if (h_pos_i.last) begin
                shifter <= glyph_load;
                reverse <= next_reverse;
                show    <= h_pos_i.active & v_pos_i.active;
            end else begin
                shifter <= {shifter[6:0], 1'b0};            // MSB first
            end
        end
    end

    assign video_o = (shifter[7] ^ reverse) & show;

endmodule

/* verilog/crtc_top.sv */
`timescale 1ns/1ps

module crtc_top (
    input  logic                        pixel_clk_i,
    input  logic                        reset_i,

    input  crtc_cfg_pkg::reg_index_t    reg_sel_i,
    input  logic [7:0]                  reg_data_i,
    input  logic                        reg_write_i,    // One clock strobe

    output raster_pkg::bus_addr_t       bus_addr_o,     // RAM below the ROM bit, ROM above
    input  logic [7:0]                  bus_data_i,     // Valid one clock after address

    output logic                        h_sync_o,
    output logic                        v_sync_o,
    output logic                        h_active_o,
    output logic                        v_active_o,
    output logic                        video_o
);
    crtc_cfg_pkg::axis_cfg_t    h_cfg;
    crtc_cfg_pkg::axis_cfg_t    v_cfg;
    raster_pkg::axis_pos_t      h_pos;
    raster_pkg::axis_pos_t      v_pos;

    crtc_regs regs (
        .pixel_clk_i (pixel_clk_i),
        .reset_i     (reset_i),
        .reg_sel_i   (reg_sel_i),
        .reg_data_i  (reg_data_i),
        .reg_write_i (reg_write_i),
        .h_cfg_o     (h_cfg),
        .v_cfg_o     (v_cfg)
    );

    raster_axis h_axis (
        .pixel_clk_i (pixel_clk_i),
        .reset_i     (reset_i),
        .step_i      (1'b1),                    // One pixel per clock
        .cfg_i       (h_cfg),
        .pos_o       (h_pos)
    );

    raster_axis v_axis (
        .pixel_clk_i (pixel_clk_i),
        .reset_i     (reset_i),
        .step_i      (h_pos.line_end),          // One scanline per line
        .cfg_i       (v_cfg),
        .pos_o       (v_pos)
    );

    char_fetch fetch (
        .pixel_clk_i   (pixel_clk_i),
        .reset_i       (reset_i),
        .h_pos_i       (h_pos),
        .v_pos_i       (v_pos),
        .h_displayed_i (h_cfg.displayed),
        .bus_addr_o    (bus_addr_o),
        .bus_data_i    (bus_data_i),
        .video_o       (video_o)
    );

    assign h_sync_o   = h_pos.sync;
    assign v_sync_o   = v_pos.sync;
    assign h_active_o = h_pos.active;
    assign v_active_o = v_pos.active;

endmodule

/* bench/crtc_sva.sv */
`timescale 1ns/1ps
`include "crtc_consts.svh"

module crtc_sva (
    input  logic                        pixel_clk_i,
    input  logic                        reset_i,
    input  logic                        h_sync_i,
    input  logic                        v_sync_i,
    input  logic                        video_i,
    input  raster_pkg::bus_addr_t       bus_addr_i,
    input  raster_pkg::axis_pos_t       h_pos_i,
    input  raster_pkg::axis_pos_t       v_pos_i,
    input  crtc_cfg_pkg::axis_cfg_t     h_cfg_i,
    input  crtc_cfg_pkg::axis_cfg_t     v_cfg_i
);
    // First character after the pulse, width 0 meaning 16
    function automatic logic [7:0] pulse_end(input logic [7:0] start,
                                             input logic [3:0] width);
        return start + ((width == 4'd0) ? 8'd16 : {4'd0, width});
    endfunction

    reset_quiet: assert property (@(posedge pixel_clk_i)
        reset_i |-> !h_sync_i && !v_sync_i && !video_i && bus_addr_i == '0)
        else $error("Outputs not idle during reset");

    // RAM fetch moves on by one column per cell within a line
    col_step: assert property (@(posedge pixel_clk_i) disable iff (reset_i)
        h_pos_i.pixel_index == 5'd0 && h_pos_i.char_index != 8'd0
        |-> bus_addr_i[10:0] == $past(bus_addr_i[10:0], `CRTC_CHAR_WIDTH + 1) + 11'd1)
        else $error("Slot 0 RAM address did not advance by one column");

    h_sync_ends: assert property (@(posedge pixel_clk_i) disable iff (reset_i)
        $fell(h_sync_i)
        |-> h_pos_i.char_index == pulse_end(h_cfg_i.sync_start, h_cfg_i.sync_width))
        else $error("Horizontal sync has the wrong width");

    v_sync_ends: assert property (@(posedge pixel_clk_i) disable iff (reset_i)
        $fell(v_sync_i)
        |-> v_pos_i.char_index == pulse_end(v_cfg_i.sync_start, v_cfg_i.sync_width))
        else $error("Vertical sync has the wrong width");

endmodule

bind crtc_top crtc_sva sva (
    .pixel_clk_i (pixel_clk_i),
    .reset_i     (reset_i),
    .h_sync_i    (h_sync_o),
    .v_sync_i    (v_sync_o),
    .video_i     (video_o),
    .bus_addr_i  (bus_addr_o),
    .h_pos_i     (h_pos),
    .v_pos_i     (v_pos),
    .h_cfg_i     (h_cfg),
    .v_cfg_i     (v_cfg)
);

/* bench/crtc_tb.sv */
`timescale 1ns/1ps
`include "crtc_consts.svh"

module crtc_tb;
    localparam int CELL          = `CRTC_CHAR_WIDTH + 1;
    localparam int DEFAULT_FRAME = 33 * 8 * 512;        // Clocks per frame after reset
    localparam int SMALL_FRAME   = (4 + 1) * 4 * 96 + 2 * 96;
    localparam int MEDIUM_FRAME  = 21 * 512;
    localparam int LIMIT_CLKS    = 2 * (DEFAULT_FRAME + 8 * SMALL_FRAME + 6 * MEDIUM_FRAME);

    logic                       pixel_clk_i;
    logic                       reset_i;
    crtc_cfg_pkg::reg_index_t   reg_sel_i;
    logic [7:0]                 reg_data_i;
    logic                       reg_write_i;
    raster_pkg::bus_addr_t      bus_addr_o;
    logic [7:0]                 bus_data_i;
    logic                       h_sync_o;
    logic                       v_sync_o;
    logic                       h_active_o;
    logic                       v_active_o;
    logic                       video_o;

    logic [7:0]                 mem [0:4095];           // RAM low half, ROM high half
    raster_pkg::bus_addr_t      addr_q;

    crtc_top DUT (.*);

    initial begin
        pixel_clk_i = 1'b0;
        forever #2 pixel_clk_i = ~pixel_clk_i;
    end

    // Synchronous memory, data one clock after the address
    always begin
        @(negedge pixel_clk_i);
        addr_q = bus_addr_o;
        @(posedge pixel_clk_i);
        #1 bus_data_i = mem[addr_q];
    end

    initial begin
        #(LIMIT_CLKS * 4);
        $display("Watchdog timeout, the DUT stopped producing the expected sync edges");
        $display("Regression failed");
        $fatal(1, "Timeout");
    end

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("** Error at %0t: %s = %0d, expected %0d", $time, name, actual, expected);
            $display("Regression failed");
            $fatal(1, "Mismatch on %s", name);
        end
    endtask

    function automatic logic probe(input int which);
        case (which)
            0:       return h_sync_o;
            1:       return v_sync_o;
            2:       return h_active_o;
            default: return v_active_o;
        endcase
    endfunction

    task automatic apply_reset();
        @(posedge pixel_clk_i);
        #1 reset_i = 1'b1;
        repeat (3) @(posedge pixel_clk_i);
        #1 reset_i = 1'b0;
    endtask

    task automatic write_reg(input logic [4:0] sel, input logic [7:0] data);
        @(posedge pixel_clk_i);
        #1;
        reg_sel_i   = sel;
        reg_data_i  = data;
        reg_write_i = 1'b1;
        @(posedge pixel_clk_i);
        #1 reg_write_i = 1'b0;
    endtask

    // Returns at the first sampled clock where the signal is high again
    task automatic wait_rise(input int which);
        logic prev;
        logic seen;
        prev = probe(which);
        seen = 1'b0;
        while (!seen) begin
            @(negedge pixel_clk_i);
            seen = !prev && probe(which);
            prev = probe(which);
        end
    endtask

    task automatic count_high(input int which, output int clks);
        clks = 0;
        while (probe(which)) begin
            clks++;
            @(negedge pixel_clk_i);
        end
    endtask

    task automatic program_small_frame();
        apply_reset();
        write_reg(`CRTC_R0, 8'd11);
        write_reg(`CRTC_R1, 8'd6);
        write_reg(`CRTC_R2, 8'd8);
        write_reg(`CRTC_R3, 8'h12);     // v width 1, h width 2
        write_reg(`CRTC_R4, 8'd4);
        write_reg(`CRTC_R5, 8'd2);
        write_reg(`CRTC_R6, 8'd3);
        write_reg(`CRTC_R7, 8'd3);
        write_reg(`CRTC_R9, 8'd3);
    endtask

    function automatic int rom_address(input logic [7:0] code, input int scan);
        return (1 << `CRTC_ROM_BASE_BIT) | (int'(code[6:0]) << 3) | (scan & 7);
    endfunction

    task automatic test_reset_timing();
        int clks;
        int high;
        apply_reset();
        @(negedge pixel_clk_i);
        check_value("h_sync_o", h_sync_o, 0);
        check_value("v_sync_o", v_sync_o, 0);
        check_value("video_o", video_o, 0);
        wait_rise(2);
        count_high(2, high);
        check_value("h_active_o high", high, 40 * CELL);
        clks = high;
        while (!h_sync_o) begin
            clks++;
            @(negedge pixel_clk_i);
        end
        check_value("h_sync_o start", clks, 48 * CELL);
        count_high(0, high);
        check_value("h_sync_o high", high, 5 * CELL);
        clks = high;
        while (!h_sync_o) begin
            clks++;
            @(negedge pixel_clk_i);
        end
        check_value("h_sync_o period", clks, 512);
    endtask

    task automatic test_small_frame();
        int lines;
        int clks;
        logic prev_h;
        program_small_frame();
        wait_rise(1);
        wait_rise(1);
        lines  = 0;
        prev_h = h_sync_o;
        do begin
            @(negedge pixel_clk_i);
            if (!prev_h && h_sync_o)
                lines++;
            prev_h = h_sync_o;
        end while (!(v_sync_o && lines > 0 && DUT.v_pos.char_index == 8'd3
                     && DUT.h_pos.char_index == 8'd0 && DUT.h_pos.pixel_index == 5'd0
                     && DUT.v_pos.pixel_index == 5'd0));
        check_value("h_sync_o pulses per frame", lines, (4 + 1) * 4 + 2);
        wait_rise(3);
        count_high(3, clks);
        check_value("v_active_o clocks", clks, 3 * 4 * 12 * CELL);
    endtask

    task automatic test_sync_widths();
        int high;
        apply_reset();
        write_reg(`CRTC_R2, 8'd44);
        write_reg(`CRTC_R4, 8'd20);
        write_reg(`CRTC_R6, 8'd1);
        write_reg(`CRTC_R7, 8'd2);
        write_reg(`CRTC_R9, 8'd0);
        write_reg(`CRTC_R3, 8'h00);     // Both widths 16
        wait_rise(1);
        wait_rise(0);
        count_high(0, high);
        check_value("h_sync_o width 0", high, 16 * CELL);
        wait_rise(1);
        count_high(1, high);
        check_value("v_sync_o width 0", high, 16 * 512);
        write_reg(`CRTC_R3, 8'h33);
        wait_rise(1);
        wait_rise(0);
        count_high(0, high);
        check_value("h_sync_o width 3", high, 3 * CELL);
        wait_rise(1);
        count_high(1, high);
        check_value("v_sync_o width 3", high, 3 * 512);
    endtask

    task automatic test_bus_schedule();
        int c;
        int r;
        program_small_frame();
        wait_rise(3);
        for (int line = 0; line < 22; line++) begin
            for (int t = 0; t < 12 * CELL; t++) begin
                c = t / CELL;
                r = line / 4;
                if (r < 3 && t % CELL == 0)
                    check_value("bus_addr_o ram", bus_addr_o, r * 6 + c);
                if (r < 3 && t % CELL == 1)
                    check_value("bus_addr_o rom", bus_addr_o,
                                rom_address(mem[r * 6 + c], line % 4));
                @(negedge pixel_clk_i);
            end
        end
    endtask

    task automatic test_video();
        int c;
        int r;
        logic [7:0] code;
        logic [7:0] glyph;
        logic expected;
        program_small_frame();
        wait_rise(3);
        for (int line = 0; line < 22; line++) begin
            for (int t = 0; t < 12 * CELL; t++) begin
                c = t / CELL;
                r = line / 4;
                expected = 1'b0;
                if (r < 3 && c >= 1 && c <= 6) begin        // Previous cell was visible
                    code     = mem[r * 6 + c - 1];
                    glyph    = mem[rom_address(code, line % 4)];
                    expected = glyph[`CRTC_CHAR_WIDTH - t % CELL] ^ code[7];
                end
                check_value("video_o", video_o, expected);
                @(negedge pixel_clk_i);
            end
        end
    endtask

    initial begin
        reset_i     = 1'b1;
        reg_sel_i   = '0;
        reg_data_i  = '0;
        reg_write_i = 1'b0;
        bus_data_i  = '0;
        void'($urandom(32'h8d0f82c5));
        for (int i = 0; i < 4096; i++)
            mem[i] = 8'($urandom);
        test_reset_timing();
        test_small_frame();
        test_sync_widths();
        test_bus_schedule();
        test_video();
        $display("Regression passed");
        $finish;
    end

endmodule

/* list.f */
+incdir+verilog
verilog/crtc_cfg_pkg.sv
verilog/raster_pkg.sv
verilog/crtc_regs.sv
verilog/raster_axis.sv
verilog/char_fetch.sv
verilog/crtc_top.sv
bench/crtc_sva.sv
bench/crtc_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the CRTC regression with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module crtc_tb \
    -f list.f \
    -o crtc_sim
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit $status
fi

./obj_dir/crtc_sim
status=$?
if [ $status -ne 0 ]; then
    echo "Simulation failed with status $status"
    exit $status
fi

exit 0
